// ==== Bender.yml ====
package:
  name: dds

sources:
  - include_dirs:
      - common
    files:
      - common/dds_pkg.sv
      - dds/dds_phase_accum.sv
      - dds/dds_cos_lut.sv
      - design/dds.sv

  - target: test
    include_dirs:
      - common
    files:
      - testbench/dds_tb.sv

// ==== common/dds_cfg.svh ====
// Build-time sizes for the multichannel cosine DDS.
// All RTL modules and the testbench take their sizes from these macros.
// DDS_LUT_ADDR_BITS must be at least 3, so that the table keeps a quadrant field.
// A larger DDS_SAMPLE_WIDTH widens the quarter-wave table entries.

`ifndef DDS_CFG_SVH
`define DDS_CFG_SVH

// width of each channel's phase accumulator
`define DDS_PHASE_BITS 24

// low phase bits that are discarded before the table lookup
`define DDS_QUANT_BITS 8

// the full-period lookup address is the top of the phase
`define DDS_LUT_ADDR_BITS (`DDS_PHASE_BITS - `DDS_QUANT_BITS)

// signed output sample width where full scale is 2^(width-1)-1
`define DDS_SAMPLE_WIDTH 16

// consecutive samples that each channel produces per clock
`define DDS_PARALLEL_SAMPLES 4

// number of independent channels
`define DDS_CHANNELS 8

`endif

// ==== common/dds_pkg.sv ====
// Shared types of the cosine DDS, sized from the configuration header.
// In the sample blocks, lane 0 is the earliest sample of a clock.
// The output block has a single valid bit for all channels.

`default_nettype none

`include "dds_cfg.svh"

package dds_pkg;

  // unsigned phase that wraps modulo 2^DDS_PHASE_BITS
  typedef logic [`DDS_PHASE_BITS-1:0] phase_t;

  // signed two's complement cosine sample
  typedef logic signed [`DDS_SAMPLE_WIDTH-1:0] sample_t;

  // the table sees the truncated phase either as a plain address or split
  // into the quadrant and the position inside that quadrant
  typedef union packed {
    logic [`DDS_LUT_ADDR_BITS-1:0] raw;
    struct packed {
      logic [1:0]                    quadrant;
      logic [`DDS_LUT_ADDR_BITS-3:0] index;
    } fold;
  } lut_addr_u;

  // one increment per channel with channel 0 in the low bits
  typedef phase_t [`DDS_CHANNELS-1:0] phase_inc_t;

  // one clock worth of samples for one channel
  typedef sample_t [`DDS_PARALLEL_SAMPLES-1:0] sample_block_t;

  // realtime output stream that has no ready
  typedef struct packed {
    sample_block_t [`DDS_CHANNELS-1:0] data;
    logic                              valid;
  } dds_out_t;

endpackage

`default_nettype wire

// ==== compile.f ====
+incdir+common
common/dds_pkg.sv
dds/dds_phase_accum.sv
dds/dds_cos_lut.sv
design/dds.sv
testbench/dds_tb.sv

// ==== dds/dds_cos_lut.sv ====
// Quarter-wave cosine lookup with a two-cycle registered read.
// The table is filled at elaboration from $cos. That works in simulation and in
// FPGA flows that evaluate initial blocks, but not in an ASIC flow.
// The output equals round((2^(W-1)-1) * cos(2*pi*addr/2^DDS_LUT_ADDR_BITS)) for every
// address. Both zero crossings and the quadrant edges are exact.

`default_nettype none

`include "dds_cfg.svh"

module dds_cos_lut (
  input  logic               clk,
  input  logic               reset,
  input  dds_pkg::lut_addr_u addr,
  output dds_pkg::sample_t   sample
);

  localparam int  INDEX_BITS = `DDS_LUT_ADDR_BITS - 2;
  localparam int  DEPTH      = 1 << INDEX_BITS;
  localparam int  MAG_BITS   = `DDS_SAMPLE_WIDTH - 1;
  localparam real FULL_SCALE = real'((1 << MAG_BITS) - 1);
  localparam real PERIOD     = real'(1 << `DDS_LUT_ADDR_BITS);
  localparam real TWO_PI     = 6.283185307179586;

  // entry i holds the cosine magnitude cos(2*pi*i/PERIOD) over the first quadrant
  logic [MAG_BITS-1:0] quarter_table [DEPTH];

  logic                  odd_quadrant;
  logic [INDEX_BITS-1:0] index_rd;
  logic                  axis_zero;

  logic [MAG_BITS-1:0]   mag_q;
  logic [1:0]            quadrant_q;
  dds_pkg::sample_t      mag_ext;

  // int'() rounds half away from zero. The rounding is therefore symmetric, and
  // negating a stored entry gives the rounded value of the negated cosine
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      quarter_table[i] = MAG_BITS'(int'(FULL_SCALE * $cos(TWO_PI * real'(i) / PERIOD)));
    end
  end

  // quadrants 1 and 3 run the table backwards. cos at (Q + i) has the magnitude
  // of cos at (Q - i), where Q is a quarter period. The two's complement of the
  // index gives Q - i, but for i = 0 it gives 0 and not Q. That point is the zero
  // crossing, so the read is forced to zero there
  assign odd_quadrant = addr.fold.quadrant[0];
  assign index_rd     = odd_quadrant ? -addr.fold.index : addr.fold.index;
  assign axis_zero    = odd_quadrant && (addr.fold.index == '0);

  // the first stage reads the table and carries the quadrant beside it
  always_ff @(posedge clk) begin
    mag_q <= axis_zero ? '0 : quarter_table[index_rd];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      quadrant_q <= '0;
    end else begin
      quadrant_q <= addr.fold.quadrant;
    end
  end

  assign mag_ext = {1'b0, mag_q};

  // the second stage negates because cosine is negative in the second and third quadrants
  always_ff @(posedge clk) begin
    if (reset) begin
      sample <= '0;
    end else if (quadrant_q[0] ^ quadrant_q[1]) begin
      sample <= -mag_ext;
    end else begin
      sample <= mag_ext;
    end
  end

endmodule

`default_nettype wire

// ==== dds/dds_phase_accum.sv ====
// Phase accumulator for one DDS channel.
// A load writes the increment register on the same edge. The next edge already
// registers phases that use the new increment.
// The accumulator is not cleared when the increment changes, so phase stays
// continuous over a frequency change.
// All arithmetic wraps modulo 2^DDS_PHASE_BITS.

`default_nettype none

`include "dds_cfg.svh"

module dds_phase_accum (
  input  logic                                         clk,
  input  logic                                         reset,
  input  logic                                         inc_load,
  input  dds_pkg::phase_t                              inc,
  output dds_pkg::phase_t [`DDS_PARALLEL_SAMPLES-1:0] phases
);

  localparam int LANES = `DDS_PARALLEL_SAMPLES;

  // increment currently in use by this channel
  dds_pkg::phase_t inc_q;

  // phase of lane 0 for the block that is emitted next
  dds_pkg::phase_t acc_q;

  // distance from lane 0 to each lane, and the advance for a whole block
  dds_pkg::phase_t [LANES-1:0] lane_offset;
  dds_pkg::phase_t             block_step;

  always_ff @(posedge clk) begin
    if (reset) begin
      inc_q <= '0;
    end else if (inc_load) begin
      inc_q <= inc;
    end
  end

  // the multiplies are by constants, so they reduce to shifts and adds.
  // Truncating the product to the phase width is the same as wrapping the phase
  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      lane_offset[k] = dds_pkg::phase_t'(inc_q * k);
    end
    block_step = dds_pkg::phase_t'(inc_q * LANES);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      acc_q <= '0;
    end else begin
      acc_q <= acc_q + block_step;
    end
  end

  // lane k carries acc + k*inc, so the lanes are consecutive samples in time.
  // They come from the same acc and inc that the advance above uses
  always_ff @(posedge clk) begin
    for (int k = 0; k < LANES; k++) begin
      phases[k] <= acc_q + lane_offset[k];
    end
  end

endmodule

`default_nettype wire

// ==== design/dds.sv ====
// Multichannel cosine DDS, top level.
// One strobe loads the increments of all channels at once. The first samples
// that use them appear 3 cycles later.
// The output is a realtime stream with no back-pressure. valid rises 3 cycles
// after reset is released and then stays high.
// There are no phase offsets, no dither and no sine output.

`default_nettype none

`include "dds_cfg.svh"

module dds (
  input  logic                clk,
  input  logic                reset,
  input  logic                phase_inc_valid,
  input  dds_pkg::phase_inc_t phase_inc,
  output dds_pkg::dds_out_t   dds_out
);

  localparam int CHANNELS = `DDS_CHANNELS;
  localparam int LANES    = `DDS_PARALLEL_SAMPLES;

  // each lookup instance drives its own element
  wire dds_pkg::sample_block_t [CHANNELS-1:0] lut_samples;

  // one stage each for the phase register and the two lookup stages
  logic [2:0] valid_q;

  for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_channel
    dds_pkg::phase_t [LANES-1:0] phases;

    dds_phase_accum u_accum (
      .clk      (clk),
      .reset    (reset),
      .inc_load (phase_inc_valid),
      .inc      (phase_inc[ch]),
      .phases   (phases)
    );

    for (genvar lane = 0; lane < LANES; lane++) begin : g_lane
      dds_pkg::lut_addr_u addr;

      // the quantization bits are dropped, and the rest of the phase is the address
      assign addr.raw = phases[lane][`DDS_PHASE_BITS-1:`DDS_QUANT_BITS];

      dds_cos_lut u_lut (
        .clk    (clk),
        .reset  (reset),
        .addr   (addr),
        .sample (lut_samples[ch][lane])
      );
    end
  end

  // every channel fills its pipeline at the same time, so one valid is enough
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[1:0], 1'b1};
    end
  end

  always_comb begin
    dds_out.data  = lut_samples;
    dds_out.valid = valid_q[2];
  end

endmodule

`default_nettype wire

// ==== testbench/dds_tb.sv ====
// Testbench for the multichannel cosine DDS.
// Increments come from a fixed seed, so every run applies the same table.
// The golden model tracks the phase of each output block directly. It uses the
// increments delayed by the 3-cycle strobe-to-output latency.
// Samples are only compared while dds_out.valid is expected high.

`default_nettype none

`include "dds_cfg.svh"

module dds_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int  CLK_PERIOD     = 8;
  localparam int  CHANNELS       = `DDS_CHANNELS;
  localparam int  LANES          = `DDS_PARALLEL_SAMPLES;
  localparam int  ROWS           = 6;
  localparam int  SINGLE_ROW     = 2;
  localparam int  ZERO_ROW       = 3;
  localparam int  LATENCY        = 3;
  localparam real SAMPLE_RATE_HZ = 6.4e9;
  localparam real TWO_PI         = 6.283185307179586;
  localparam real FULL_SCALE     = real'((1 << (`DDS_SAMPLE_WIDTH - 1)) - 1);

  logic                clk;
  logic                reset;
  logic                phase_inc_valid;
  dds_pkg::phase_inc_t phase_inc;
  dds_pkg::dds_out_t   dds_out;

  // stimulus table with one increment word and one hold length per row
  dds_pkg::phase_inc_t row_inc [ROWS];
  int                  row_hold [ROWS];
  int                  row_freq [ROWS][CHANNELS];
  real                 freq_mhz [4] = '{12.13, 517.036, 1729.725, 2.759};

  integer seed;
  int     total_hold;
  logic   table_ready;

  // inc_line[0] mirrors the increment register and inc_out is the increment
  // that the current output block uses
  dds_pkg::phase_inc_t inc_line [LATENCY];
  dds_pkg::phase_inc_t inc_out;
  dds_pkg::phase_t     acc_out [CHANNELS];
  int                  low_edges;
  logic [3:0]          quadrant_seen;
  logic                wrap_seen;

  dds UUT (
    .clk             (clk),
    .reset           (reset),
    .phase_inc_valid (phase_inc_valid),
    .phase_inc       (phase_inc),
    .dds_out         (dds_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic dds_pkg::phase_t freq_to_inc(input real mhz);
    real steps;
    steps = mhz * 1.0e6 / SAMPLE_RATE_HZ * real'(1 << `DDS_PHASE_BITS);
    return dds_pkg::phase_t'($rtoi(steps + 0.5));
  endfunction

  // round(full scale * cos) over the whole period with halves rounded away from zero
  function automatic dds_pkg::sample_t cosine_rule(input dds_pkg::phase_t ph);
    dds_pkg::lut_addr_u addr;
    real                angle;
    real                scaled;
    addr.raw = ph[`DDS_PHASE_BITS-1:`DDS_QUANT_BITS];
    angle    = TWO_PI * real'(addr.raw) / real'(1 << `DDS_LUT_ADDR_BITS);
    scaled   = FULL_SCALE * $cos(angle);
    if (scaled >= 0.0) begin
      return dds_pkg::sample_t'($rtoi(scaled + 0.5));
    end
    return dds_pkg::sample_t'(-$rtoi(-scaled + 0.5));
  endfunction

  task automatic check_sample(input dds_pkg::sample_t got, input dds_pkg::sample_t expected,
                              input int ch, input int lane);
    if (got !== expected) begin
      $display("Mismatch at %0t ns: channel %0d lane %0d sample %0d, expected %0d",
               $time, ch, lane, got, expected);
      $display("RESULT: FAIL");
      $fatal(1, "sample compare failed");
    end
  endtask

  task automatic check_valid(input logic got, input logic expected);
    if (got !== expected) begin
      $display("Mismatch at %0t ns: dds_out.valid is %b, expected %b", $time, got, expected);
      $display("RESULT: FAIL");
      $fatal(1, "valid compare failed");
    end
  endtask

  task automatic build_table();
    int ch;
    total_hold = 0;
    for (int r = 0; r < ROWS; r++) begin
      if (r == ZERO_ROW) begin
        for (int c = 0; c < CHANNELS; c++) begin
          row_freq[r][c] = 0;
        end
        row_inc[r] = '0;
      end else if (r == SINGLE_ROW) begin
        // only one channel moves to a different frequency
        row_freq[r] = row_freq[r-1];
        row_inc[r]  = row_inc[r-1];
        ch = $unsigned($random(seed)) % CHANNELS;
        row_freq[r][ch] = (row_freq[r-1][ch] + 1 + $unsigned($random(seed)) % 3) % 4;
        row_inc[r][ch]  = freq_to_inc(freq_mhz[row_freq[r][ch]]);
      end else begin
        for (int c = 0; c < CHANNELS; c++) begin
          row_freq[r][c] = $unsigned($random(seed)) % 4;
          row_inc[r][c]  = freq_to_inc(freq_mhz[row_freq[r][c]]);
        end
      end
      row_hold[r] = 40 + $unsigned($random(seed)) % 81;
      total_hold += row_hold[r];
    end
  endtask

  // applies the effect of the clock edge that has just passed, using the inputs
  // that were held across that edge
  task automatic model_edge();
    logic [`DDS_PHASE_BITS:0] sum;
    if (reset) begin
      for (int i = 0; i < LATENCY; i++) begin
        inc_line[i] = '0;
      end
      inc_out = '0;
      for (int c = 0; c < CHANNELS; c++) begin
        acc_out[c] = '0;
      end
      low_edges = 0;
    end else begin
      for (int c = 0; c < CHANNELS; c++) begin
        sum = {1'b0, acc_out[c]} + {1'b0, dds_pkg::phase_t'(inc_out[c] * LANES)};
        if (sum[`DDS_PHASE_BITS] && low_edges >= LATENCY) begin
          wrap_seen = 1'b1;
        end
        acc_out[c] = sum[`DDS_PHASE_BITS-1:0];
      end
      inc_out = inc_line[LATENCY-1];
      for (int i = LATENCY - 1; i > 0; i--) begin
        inc_line[i] = inc_line[i-1];
      end
      if (phase_inc_valid) begin
        inc_line[0] = phase_inc;
      end
      low_edges++;
    end
  endtask

  task automatic compare_outputs();
    dds_pkg::phase_t    ph;
    dds_pkg::lut_addr_u addr;
    logic               expect_valid;
    expect_valid = !reset && (low_edges >= LATENCY);
    check_valid(dds_out.valid, expect_valid);
    if (expect_valid) begin
      for (int c = 0; c < CHANNELS; c++) begin
        for (int lane = 0; lane < LANES; lane++) begin
          ph       = dds_pkg::phase_t'(acc_out[c] + inc_out[c] * lane);
          addr.raw = ph[`DDS_PHASE_BITS-1:`DDS_QUANT_BITS];
          quadrant_seen[addr.fold.quadrant] = 1'b1;
          check_sample(dds_out.data[c][lane], cosine_rule(ph), c, lane);
        end
      end
    end
  endtask

  // outputs are stable at the falling edge, and inputs change right after
  task automatic step_cycle();
    @(negedge clk);
    model_edge();
    compare_outputs();
  endtask

  initial begin
    wait (table_ready);
    #((total_hold + 50) * CLK_PERIOD);
    $display("Run timed out after %0d cycles without finishing the stimulus table",
             total_hold + 50);
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    table_ready     = 1'b0;
    reset           = 1'b1;
    phase_inc_valid = 1'b0;
    phase_inc       = '0;
    seed            = 32'h64f1883d;
    quadrant_seen   = '0;
    wrap_seen       = 1'b0;
    low_edges       = 0;
    inc_out         = '0;
    for (int i = 0; i < LATENCY; i++) begin
      inc_line[i] = '0;
    end
    for (int c = 0; c < CHANNELS; c++) begin
      acc_out[c] = '0;
    end
    build_table();
    table_ready = 1'b1;

    repeat (3) step_cycle();
    reset = 1'b0;

    for (int r = 0; r < ROWS; r++) begin
      phase_inc_valid = 1'b1;
      phase_inc       = row_inc[r];
      step_cycle();
      phase_inc_valid = 1'b0;
      repeat (row_hold[r]) step_cycle();
    end

    // let the last increment reach the output
    repeat (LATENCY + 1) step_cycle();

    if (quadrant_seen != 4'b1111 || !wrap_seen) begin
      $display("Stimulus did not cover every quadrant and an accumulator wrap (%b, %b)",
               quadrant_seen, wrap_seen);
      $display("RESULT: FAIL");
      $fatal(1, "coverage incomplete");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire
